// ==== src/ahb_pkg.sv ====
// ahb-lite bus widths plus htrans and hresp encodings
package ahb_pkg;

  // ===================================================================
  // bus widths
  // ===================================================================

  // one 32-bit word per transfer
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // ===================================================================
  // encodings
  // ===================================================================

  // transfer type in the standard amba encoding
  // only IDLE and NONSEQ are issued in this subsystem
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // lite bus keeps only okay and error
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } hresp_t;

endpackage

// ==== src/ahb_map_pkg.sv ====
// address map with slave count and inclusive region bounds per slave
package ahb_map_pkg;

  // ===================================================================
  // mapped slaves
  // ===================================================================

  // memory slaves on the bus
  // the default slave is not counted here
  localparam int slave_num = 2;

  // one full-width address per slave, index 0 in the low word
  typedef logic [slave_num-1:0][ahb_pkg::addr_w-1:0] bound_array_t;

  // ===================================================================
  // region bounds
  // ===================================================================

  // both bounds are inclusive and compared over the whole address
  // slave 0 holds 1 KB, slave 1 holds 256 bytes
  localparam bound_array_t low_addr = {
    32'h0000_2400,
    32'h0000_2000
  };

  // last byte of each region
  localparam bound_array_t high_addr = {
    32'h0000_24FF,
    32'h0000_23FF
  };

  // anything outside both ranges goes to the default slave

endpackage

// ==== src/ahb_master.sv ====
// ahb master with command capture, three-state transfer fsm and response pulse
`timescale 1ns/1ps

module ahb_master (
  input  logic                       hclk,
  input  logic                       rst_n,
  // command side
  input  logic                       cmd_valid,
  input  logic                       cmd_write,
  input  logic [ahb_pkg::addr_w-1:0] cmd_addr,
  input  logic [ahb_pkg::data_w-1:0] cmd_wdata,
  output logic                       cmd_busy,
  output logic                       rsp_valid,
  output logic [ahb_pkg::data_w-1:0] rsp_rdata,
  output logic                       rsp_error,
  // bus side
  output logic [ahb_pkg::addr_w-1:0] haddr,
  output ahb_pkg::htrans_t           htrans,
  output logic                       hwrite,
  output logic [ahb_pkg::data_w-1:0] hwdata,
  input  logic                       hready,
  input  ahb_pkg::hresp_t            hresp,
  input  logic [ahb_pkg::data_w-1:0] hrdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_t;

  state_t                     state_q;
  logic [ahb_pkg::addr_w-1:0] addr_q;
  logic                       write_q;
  logic [ahb_pkg::data_w-1:0] wdata_q;
  logic                       data_done;

  // data phase closes on the edge where the shared hready is high
  assign data_done = (state_q == st_data) && hready;

  // ===================================================================
  // transfer fsm
  // ===================================================================

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state_q <= st_idle;
      write_q <= 1'b0;
    end else begin
      unique case (state_q)
        st_idle: begin
          if (cmd_valid) begin
            state_q <= st_addr;
            write_q <= cmd_write;
          end
        end
        // address phase accepted when hready is high
        st_addr: begin
          if (hready) begin
            state_q <= st_data;
          end
        end
        st_data: begin
          if (hready) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // command payload, held for the whole transfer
  always_ff @(posedge hclk) begin
    if ((state_q == st_idle) && cmd_valid) begin
      addr_q  <= cmd_addr;
      wdata_q <= cmd_wdata;
    end
  end

  // ===================================================================
  // bus drive and response
  // ===================================================================

  // busy from acceptance until the edge that raises rsp_valid
  assign cmd_busy = (state_q != st_idle);

  assign haddr  = addr_q;
  assign hwrite = write_q;
  // one NONSEQ address phase per command
  assign htrans = (state_q == st_addr) ? ahb_pkg::NONSEQ : ahb_pkg::IDLE;
  // write data only in the data phase
  assign hwdata = (state_q == st_data) ? wdata_q : '0;

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_error <= 1'b0;
    end else begin
      rsp_valid <= data_done;
      if (data_done) begin
        rsp_error <= (hresp == ahb_pkg::ERROR);
      end
    end
  end

  // read data is captured for reads only
  always_ff @(posedge hclk) begin
    if (data_done && !write_q) begin
      rsp_rdata <= hrdata;
    end
  end

  // ===================================================================
  // checks
  // ===================================================================

  // strobe while busy would be dropped by the fsm
  a_no_cmd_when_busy: assert property (@(posedge hclk) disable iff (!rst_n)
    cmd_busy |-> !cmd_valid)
    else $error("ahb_master: cmd_valid while cmd_busy");

  // every new NONSEQ comes from a command accepted one cycle earlier
  a_nonseq_from_cmd: assert property (@(posedge hclk) disable iff (!rst_n)
    $rose(htrans == ahb_pkg::NONSEQ) |-> $past(cmd_valid && !cmd_busy))
    else $error("ahb_master: NONSEQ without an accepted command");

endmodule

// ==== src/ahb_decoder.sv ====
// address decoder with inclusive region compare, slave selects and default select
`timescale 1ns/1ps

module ahb_decoder #(
  parameter int slave_num = ahb_map_pkg::slave_num
) (
  input  logic [ahb_pkg::addr_w-1:0] haddr,
  input  ahb_pkg::htrans_t           htrans,
  output logic [slave_num-1:0]       hsel,
  output logic                       default_sel
);

  logic [slave_num-1:0] region_hit;
  logic                 active;

  // IDLE carries no transfer so nothing is selected
  assign active = (htrans != ahb_pkg::IDLE);

  // ===================================================================
  // region compare
  // ===================================================================

  // full address against both bounds
  // bounds are inclusive so the last word of a region still hits
  for (genvar i = 0; i < slave_num; i++) begin : g_region
    assign region_hit[i] = (haddr >= ahb_map_pkg::low_addr[i]) &&
                           (haddr <= ahb_map_pkg::high_addr[i]);
  end

  // ===================================================================
  // selects
  // ===================================================================

  // zero-cycle path from haddr and htrans
  assign hsel = active ? region_hit : '0;

  // hole in the map
  // default slave answers with ERROR
  assign default_sel = active && !(|region_hit);

  // ===================================================================
  // checks
  // ===================================================================

  // regions in the map package must not overlap
  // one owner at most per transfer, default slave included
  // checked only once the bus inputs are known after reset
  always_comb begin
    if (!$isunknown({haddr, htrans})) begin
      assert ($onehot0({default_sel, hsel}))
        else $error("ahb_decoder: more than one select at %h", haddr);
    end
  end

endmodule

// ==== src/ahb_slave_mem.sv ====
// zero-wait word memory slave with address-phase register and word array
`timescale 1ns/1ps

module ahb_slave_mem #(
  parameter int depth_words = 256
) (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic                       hsel,
  input  logic [ahb_pkg::addr_w-1:0] haddr,
  input  ahb_pkg::htrans_t           htrans,
  input  logic                       hwrite,
  input  logic [ahb_pkg::data_w-1:0] hwdata,
  input  logic                       hready,
  output logic [ahb_pkg::data_w-1:0] hrdata,
  output logic                       hreadyout,
  output ahb_pkg::hresp_t            hresp
);

  // word index taken from the low address bits above the byte lane
  localparam int idx_w = $clog2(depth_words);

  logic [ahb_pkg::data_w-1:0] mem [depth_words];
  logic                       accept;
  logic                       sel_q;
  logic                       write_q;
  logic [idx_w-1:0]           idx_q;

  // ===================================================================
  // address phase
  // ===================================================================

  // active transfer to this slave while the bus is ready
  assign accept = hready && hsel &&
                  (htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ});

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      sel_q   <= 1'b0;
      write_q <= 1'b0;
    end else if (hready) begin
      // new data phase starts on every ready edge
      sel_q   <= accept;
      write_q <= accept && hwrite;
    end
  end

  // index only matters while sel_q is set
  always_ff @(posedge hclk) begin
    if (accept) begin
      idx_q <= haddr[idx_w+1:2];
    end
  end

  // ===================================================================
  // data phase
  // ===================================================================

  // write lands at the end of the data phase
  always_ff @(posedge hclk) begin
    if (sel_q && write_q && hready) begin
      mem[idx_q] <= hwdata;
    end
  end

  // read word goes out in the same data phase
  // zero when this slave does not own a read
  assign hrdata = (sel_q && !write_q) ? mem[idx_q] : '0;

  // no wait states and no error from a mapped memory
  assign hreadyout = 1'b1;
  assign hresp     = ahb_pkg::OKAY;

endmodule

// ==== src/ahb_default_slave.sv ====
// default slave with the two-cycle ERROR response for unmapped transfers
`timescale 1ns/1ps

module ahb_default_slave (
  input  logic             hclk,
  input  logic             rst_n,
  input  logic             default_sel,
  input  ahb_pkg::htrans_t htrans,
  input  logic             hready,
  output logic             hreadyout,
  output ahb_pkg::hresp_t  hresp
);

  typedef enum logic [1:0] {
    ds_okay,
    ds_err_first,
    ds_err_last
  } ds_state_t;

  ds_state_t state_q;
  logic      accept;

  // unmapped transfer taken on a ready edge
  assign accept = hready && default_sel &&
                  (htrans inside {ahb_pkg::NONSEQ, ahb_pkg::SEQ});

  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      state_q <= ds_okay;
    end else begin
      unique case (state_q)
        ds_okay: begin
          if (accept) begin
            state_q <= ds_err_first;
          end
        end
        // hreadyout low here so no new address is accepted
        ds_err_first: state_q <= ds_err_last;
        // a following unmapped transfer may start on this ready edge
        ds_err_last: state_q <= accept ? ds_err_first : ds_okay;
        default: state_q <= ds_okay;
      endcase
    end
  end

  // wait on the first cycle, ERROR held for both cycles
  assign hreadyout = (state_q != ds_err_first);
  assign hresp     = (state_q == ds_okay) ? ahb_pkg::OKAY : ahb_pkg::ERROR;

  // completing ERROR cycle always follows the waiting ERROR cycle
  a_error_two_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
    (hresp == ahb_pkg::ERROR) && hreadyout |->
      $past((hresp == ahb_pkg::ERROR) && !hreadyout))
    else $error("ahb_default_slave: single-cycle ERROR response");

endmodule

// ==== src/ahb_read_mux.sv ====
// read-response multiplexer with data-phase owner register and response steering
`timescale 1ns/1ps

module ahb_read_mux #(
  parameter int slave_num = ahb_map_pkg::slave_num
) (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic [slave_num-1:0]       hsel,
  input  logic                       default_sel,
  input  logic                       hready_in0,
  input  logic                       hready_in1,
  input  ahb_pkg::hresp_t            hresp_in0,
  input  ahb_pkg::hresp_t            hresp_in1,
  input  logic [ahb_pkg::data_w-1:0] hrdata_in0,
  input  logic [ahb_pkg::data_w-1:0] hrdata_in1,
  input  logic                       hready_def,
  input  ahb_pkg::hresp_t            hresp_def,
  output logic                       hready,
  output ahb_pkg::hresp_t            hresp,
  output logic [ahb_pkg::data_w-1:0] hrdata
);

  logic [slave_num-1:0] owner_q;
  logic                 owner_def_q;

  // address-phase selects become the data-phase owner on a ready edge
  always_ff @(posedge hclk) begin
    if (!rst_n) begin
      owner_q     <= '0;
      owner_def_q <= 1'b0;
    end else if (hready) begin
      owner_q     <= hsel;
      owner_def_q <= default_sel;
    end
  end

  // idle bus answers ready and OKAY
  always_comb begin
    hready = 1'b1;
    hresp  = ahb_pkg::OKAY;
    hrdata = '0;
    if (owner_def_q) begin
      hready = hready_def;
      hresp  = hresp_def;
    end else if (owner_q[0]) begin
      hready = hready_in0;
      hresp  = hresp_in0;
      hrdata = hrdata_in0;
    end else if (owner_q[1]) begin
      hready = hready_in1;
      hresp  = hresp_in1;
      hrdata = hrdata_in1;
    end
  end

  // only the default slave stalls and never for more than one cycle
  a_single_wait: assert property (@(posedge hclk) disable iff (!rst_n)
    !hready |=> hready)
    else $error("ahb_read_mux: hready low for more than one cycle");

endmodule

// ==== src/ahb_subsys_top.sv ====
// subsystem top with master, decoder, two memory slaves, default slave and read mux
`timescale 1ns/1ps

module ahb_subsys_top #(
  parameter int slave_num    = ahb_map_pkg::slave_num,
  parameter int depth0_words = 256,
  parameter int depth1_words = 64
) (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  logic                       cmd_write,
  input  logic [ahb_pkg::addr_w-1:0] cmd_addr,
  input  logic [ahb_pkg::data_w-1:0] cmd_wdata,
  output logic                       cmd_busy,
  output logic                       rsp_valid,
  output logic [ahb_pkg::data_w-1:0] rsp_rdata,
  output logic                       rsp_error
);

  // master to everyone
  logic [ahb_pkg::addr_w-1:0] haddr;
  ahb_pkg::htrans_t           htrans;
  logic                       hwrite;
  logic [ahb_pkg::data_w-1:0] hwdata;
  // decoder outputs
  logic [slave_num-1:0]       hsel;
  logic                       default_sel;
  // shared return path from the mux
  logic                       hready;
  ahb_pkg::hresp_t            hresp;
  logic [ahb_pkg::data_w-1:0] hrdata;
  // per-slave responses
  logic [ahb_pkg::data_w-1:0] s0_hrdata;
  logic [ahb_pkg::data_w-1:0] s1_hrdata;
  logic                       s0_hreadyout;
  logic                       s1_hreadyout;
  ahb_pkg::hresp_t            s0_hresp;
  ahb_pkg::hresp_t            s1_hresp;
  logic                       def_hreadyout;
  ahb_pkg::hresp_t            def_hresp;

  // ===================================================================
  // producer side
  // ===================================================================

  ahb_master master_i (
    .hclk(hclk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_write(cmd_write),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
    .cmd_busy(cmd_busy), .rsp_valid(rsp_valid),
    .rsp_rdata(rsp_rdata), .rsp_error(rsp_error),
    .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
    .hready(hready), .hresp(hresp), .hrdata(hrdata)
  );

  ahb_decoder #(.slave_num(slave_num)) decoder_i (
    .haddr(haddr), .htrans(htrans),
    .hsel(hsel), .default_sel(default_sel)
  );

  // ===================================================================
  // consumer side
  // ===================================================================

  // 1 KB region at 0x2000
  ahb_slave_mem #(.depth_words(depth0_words)) mem0_i (
    .hclk(hclk), .rst_n(rst_n), .hsel(hsel[0]),
    .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
    .hready(hready), .hrdata(s0_hrdata),
    .hreadyout(s0_hreadyout), .hresp(s0_hresp)
  );

  // 256-byte region at 0x2400
  ahb_slave_mem #(.depth_words(depth1_words)) mem1_i (
    .hclk(hclk), .rst_n(rst_n), .hsel(hsel[1]),
    .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata),
    .hready(hready), .hrdata(s1_hrdata),
    .hreadyout(s1_hreadyout), .hresp(s1_hresp)
  );

  ahb_default_slave default_i (
    .hclk(hclk), .rst_n(rst_n), .default_sel(default_sel),
    .htrans(htrans), .hready(hready),
    .hreadyout(def_hreadyout), .hresp(def_hresp)
  );

  ahb_read_mux #(.slave_num(slave_num)) read_mux_i (
    .hclk(hclk), .rst_n(rst_n), .hsel(hsel), .default_sel(default_sel),
    .hready_in0(s0_hreadyout), .hready_in1(s1_hreadyout),
    .hresp_in0(s0_hresp), .hresp_in1(s1_hresp),
    .hrdata_in0(s0_hrdata), .hrdata_in1(s1_hrdata),
    .hready_def(def_hreadyout), .hresp_def(def_hresp),
    .hready(hready), .hresp(hresp), .hrdata(hrdata)
  );

endmodule

// ==== bench/tb_checker.sv ====
// response checker with reset idle check, latency, busy, error flag and read data compare
`timescale 1ns/1ps

module tb_checker (
  input  logic                       hclk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  logic                       cmd_busy,
  input  logic                       rsp_valid,
  input  logic [ahb_pkg::data_w-1:0] rsp_rdata,
  input  logic                       rsp_error,
  input  logic                       exp_valid,
  input  logic [ahb_pkg::data_w-1:0] exp_rdata,
  input  logic                       exp_error,
  input  logic                       exp_is_read,
  input  logic [8*24-1:0]            exp_name,
  input  int                         test_idx,
  input  logic                       all_sent,
  output int                         pass_count,
  output int                         fail_count,
  output logic                       done
);

  // cycles from the accepted strobe to the response pulse
  localparam int okay_latency      = 3;
  localparam int error_latency     = 4;
  localparam int rsp_limit         = 10;
  localparam int cmd_limit         = 40;
  localparam int reset_limit       = 20;
  localparam int reset_idle_cycles = 4;

  // expected values latched at the accept sample
  logic [ahb_pkg::data_w-1:0] want_rdata;
  logic                       want_error;
  logic                       want_read;
  logic [8*24-1:0]            want_name;
  int                         want_idx;
  int                         test_errors;

  // strobe taken by the master at the next rising edge
  function automatic logic cmd_accepted();
    return exp_valid && cmd_valid && !cmd_busy;
  endfunction

  // ===================================================================
  // reset and idle
  // ===================================================================

  task automatic wait_for_reset(output logic ok);
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < reset_limit) begin
      @(negedge hclk);
      waited++;
    end
    ok = (rst_n === 1'b1);
    if (!ok) begin
      $display("error: reset was not released within %0d cycles", reset_limit);
    end
  endtask

  // nothing busy and no response before the first command
  task automatic check_reset_idle();
    int cycles;
    test_errors = 0;
    for (cycles = 0; cycles < reset_idle_cycles; cycles++) begin
      @(negedge hclk);
      if (cmd_busy || rsp_valid) begin
        $display("error: reset_idle: cmd_busy or rsp_valid high with no command");
        test_errors++;
      end
    end
    if (test_errors == 0) begin
      $display("test 0 reset_idle: ok");
      pass_count++;
    end else begin
      $display("test 0 reset_idle: failed");
      fail_count++;
    end
  endtask

  // looks at the current sample first, so a strobe in the rsp_valid cycle is seen
  task automatic wait_for_cmd(output logic got);
    int waited;
    waited = 0;
    while (!cmd_accepted() && !all_sent && waited < cmd_limit) begin
      @(negedge hclk);
      waited++;
      if (!cmd_accepted() && (rsp_valid || cmd_busy)) begin
        $display("error: rsp_valid or cmd_busy high with no command in flight");
        fail_count++;
      end
    end
    got = cmd_accepted();
    if (!got && !all_sent) begin
      $display("error: no command arrived within %0d cycles", cmd_limit);
      fail_count++;
    end
    if (got) begin
      want_rdata = exp_rdata;
      want_error = exp_error;
      want_read  = exp_is_read;
      want_name  = exp_name;
      want_idx   = test_idx;
    end
  endtask

  // ===================================================================
  // response compare
  // ===================================================================

  task automatic check_response(output logic ok);
    int lat;
    int want_lat;
    test_errors = 0;
    want_lat = want_error ? error_latency : okay_latency;
    @(negedge hclk);
    lat = 1;
    while (!rsp_valid && lat < rsp_limit) begin
      // transfer still in flight
      if (!cmd_busy) begin
        $display("error: test %0d %0s: cmd_busy low before the response", want_idx,
                 want_name);
        test_errors++;
      end
      @(negedge hclk);
      lat++;
    end
    ok = rsp_valid;
    if (!ok) begin
      $display("error: test %0d %0s: no response within %0d cycles", want_idx, want_name,
               rsp_limit);
      test_errors++;
    end else begin
      if (lat != want_lat) begin
        $display("mismatch test %0d %0s: latency expected %0d actual %0d", want_idx,
                 want_name, want_lat, lat);
        test_errors++;
      end
      if (rsp_error !== want_error) begin
        $display("mismatch test %0d %0s: rsp_error expected %0b actual %0b", want_idx,
                 want_name, want_error, rsp_error);
        test_errors++;
      end
      // read data only means something on an OKAY read
      if (want_read && !want_error && rsp_rdata !== want_rdata) begin
        $display("mismatch test %0d %0s: rsp_rdata expected %h actual %h", want_idx,
                 want_name, want_rdata, rsp_rdata);
        test_errors++;
      end
    end
    if (test_errors == 0) begin
      $display("test %0d %0s: ok", want_idx, want_name);
      pass_count++;
    end else begin
      $display("test %0d %0s: failed", want_idx, want_name);
      fail_count++;
    end
  endtask

  initial begin
    logic rst_ok;
    logic got;
    logic rsp_ok;
    pass_count = 0;
    fail_count = 0;
    done       = 1'b0;
    wait_for_reset(rst_ok);
    if (!rst_ok) begin
      fail_count++;
    end else begin
      check_reset_idle();
      got    = 1'b1;
      rsp_ok = 1'b1;
      // one transfer in flight at a time
      while (got && rsp_ok) begin
        wait_for_cmd(got);
        if (got) begin
          check_response(rsp_ok);
        end
      end
    end
    done = 1'b1;
  end

endmodule

// ==== bench/tb_top.sv ====
// testbench top with clock, reset, trace reader, command driver, checker and the DUT
`timescale 1ns/1ps

module tb_top;

  localparam int clk_period  = 20;
  localparam int drive_delay = 2;
  localparam int busy_limit  = 20;
  localparam int done_limit  = 50;

  logic                       hclk;
  logic                       rst_n;
  logic                       cmd_valid;
  logic                       cmd_write;
  logic [ahb_pkg::addr_w-1:0] cmd_addr;
  logic [ahb_pkg::data_w-1:0] cmd_wdata;
  logic                       cmd_busy;
  logic                       rsp_valid;
  logic [ahb_pkg::data_w-1:0] rsp_rdata;
  logic                       rsp_error;
  // expected values toward the checker
  logic                       exp_valid;
  logic [ahb_pkg::data_w-1:0] exp_rdata;
  logic                       exp_error;
  logic                       exp_is_read;
  logic [8*24-1:0]            exp_name;
  int                         test_idx;
  logic                       all_sent;
  int                         pass_count;
  int                         fail_count;
  logic                       checker_done;
  // trace state
  integer                     seed;
  int                         fd;
  logic                       abort;
  // random words by address, for the matching read
  logic [ahb_pkg::data_w-1:0] rnd_word [logic [ahb_pkg::addr_w-1:0]];

  ahb_subsys_top dut_i (
    .hclk(hclk), .rst_n(rst_n),
    .cmd_valid(cmd_valid), .cmd_write(cmd_write),
    .cmd_addr(cmd_addr), .cmd_wdata(cmd_wdata),
    .cmd_busy(cmd_busy), .rsp_valid(rsp_valid),
    .rsp_rdata(rsp_rdata), .rsp_error(rsp_error)
  );

  tb_checker checker_i (
    .hclk(hclk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd_busy(cmd_busy),
    .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_error(rsp_error),
    .exp_valid(exp_valid), .exp_rdata(exp_rdata), .exp_error(exp_error),
    .exp_is_read(exp_is_read), .exp_name(exp_name), .test_idx(test_idx),
    .all_sent(all_sent), .pass_count(pass_count), .fail_count(fail_count),
    .done(checker_done)
  );

  initial begin
    hclk = 1'b0;
    forever #(clk_period / 2) hclk = ~hclk;
  end

  // ===================================================================
  // command driver
  // ===================================================================

  // called 2 ns after a rising edge, returns 2 ns after the next one
  task automatic send_cmd(input logic [8*24-1:0]            name,
                          input logic                       write,
                          input logic [ahb_pkg::addr_w-1:0] addr,
                          input logic [ahb_pkg::data_w-1:0] wdata,
                          input logic [ahb_pkg::data_w-1:0] rdata,
                          input logic                       error);
    int waited;
    waited = 0;
    while (cmd_busy && waited < busy_limit) begin
      @(posedge hclk);
      #(drive_delay);
      waited++;
    end
    if (cmd_busy) begin
      $display("error: cmd_busy stayed high before %0s", name);
      abort = 1'b1;
    end else begin
      cmd_valid   = 1'b1;
      cmd_write   = write;
      cmd_addr    = addr;
      cmd_wdata   = write ? wdata : '0;
      exp_valid   = 1'b1;
      exp_is_read = !write;
      exp_rdata   = rdata;
      exp_error   = error;
      exp_name    = name;
      test_idx++;
      @(posedge hclk);
      #(drive_delay);
      cmd_valid = 1'b0;
      exp_valid = 1'b0;
    end
  endtask

  // ===================================================================
  // trace run
  // ===================================================================

  initial begin
    string                      line;
    logic [8*24-1:0]            name;
    int                         op;
    logic [ahb_pkg::addr_w-1:0] addr;
    logic [ahb_pkg::data_w-1:0] wdata;
    logic [ahb_pkg::data_w-1:0] rdata;
    int                         err;
    int                         fields;
    int                         waited;
    seed        = 55;
    abort       = 1'b0;
    all_sent    = 1'b0;
    test_idx    = 0;
    cmd_valid   = 1'b0;
    cmd_write   = 1'b0;
    cmd_addr    = '0;
    cmd_wdata   = '0;
    exp_valid   = 1'b0;
    exp_rdata   = '0;
    exp_error   = 1'b0;
    exp_is_read = 1'b0;
    exp_name    = '0;
    rst_n       = 1'b0;
    repeat (4) @(posedge hclk);
    #(drive_delay);
    rst_n = 1'b1;
    // quiet bus for the reset idle check
    repeat (6) @(posedge hclk);
    #(drive_delay);

    fd = $fopen("bench/ahb_trace.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open bench/ahb_trace.txt");
      abort = 1'b1;
    end
    while (!abort && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      fields = $sscanf(line, "%s %d %h %h %h %d", name, op, addr, wdata, rdata, err);
      // comment and blank lines carry no transfer
      if (line.len() > 0 && line.getc(0) != "#" && fields == 6) begin
        if (op == 2) begin
          wdata = $random(seed);
          rnd_word[addr] = wdata;
        end else if (op == 3) begin
          if (rnd_word.exists(addr)) begin
            rdata = rnd_word[addr];
          end else begin
            $display("error: %0s reads a random word that was never written", name);
            abort = 1'b1;
          end
        end
        if (!abort) begin
          send_cmd(name, (op == 1) || (op == 2), addr, wdata, rdata, err != 0);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    all_sent = 1'b1;

    waited = 0;
    while (!checker_done && waited < done_limit) begin
      @(posedge hclk);
      waited++;
    end
    if (!checker_done) begin
      $display("error: checker did not finish within %0d cycles", done_limit);
      abort = 1'b1;
    end else if (pass_count + fail_count != test_idx + 1) begin
      $display("error: checker reported %0d tests but %0d were run",
               pass_count + fail_count, test_idx + 1);
      abort = 1'b1;
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (!abort && fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== ahb_subsys_top.f ====
src/ahb_pkg.sv
src/ahb_map_pkg.sv
src/ahb_master.sv
src/ahb_decoder.sv
src/ahb_slave_mem.sv
src/ahb_default_slave.sv
src/ahb_read_mux.sv
src/ahb_subsys_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the AHB subsystem testbench with Verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_top \
  -f ahb_subsys_top.f -o tb_top_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_top_sim > sim.log 2>&1 \
  || echo "simulator exited with an error status"

cat sim.log

grep -qx "sim passed" sim.log && echo "result: pass" && exit 0 \
  || { echo "result: fail"; exit 1; }

// ==== bench/ahb_trace.txt ====
# columns: name op addr wdata exp_rdata exp_error (hex for addr and data)
# op 0 read, 1 write, 2 write a random word, 3 read back that random word
wr_s0_first      1 00002000 11112222 00000000 0
wr_s0_last       1 000023fc 33334444 00000000 0
wr_s1_first      1 00002400 55556666 00000000 0
wr_s1_last       1 000024fc 77778888 00000000 0
rd_s0_first      0 00002000 00000000 11112222 0
rd_s0_last       0 000023fc 00000000 33334444 0
rd_s1_first      0 00002400 00000000 55556666 0
rd_s1_last       0 000024fc 00000000 77778888 0
wr_below_s0      1 00001ffc deadbeef 00000000 1
wr_above_s1      1 00002500 deadbeef 00000000 1
wr_zero          1 00000000 deadbeef 00000000 1
rd_above_s1      0 00002500 00000000 00000000 1
rd_keep_s0_last  0 000023fc 00000000 33334444 0
rd_keep_s1_first 0 00002400 00000000 55556666 0
rd_keep_s0_first 0 00002000 00000000 11112222 0
alt_s0_wr_rnd    2 00002100 00000000 00000000 0
alt_unmap_rd     0 00003000 00000000 00000000 1
alt_s1_wr_rnd    2 00002480 00000000 00000000 0
alt_unmap_wr     1 0000fffc 0badf00d 00000000 1
alt_s0_rd_rnd    3 00002100 00000000 00000000 0
alt_unmap_rd2    0 80000000 00000000 00000000 1
alt_s1_rd_rnd    3 00002480 00000000 00000000 0
